// File: verilog/rv_exec_settings.svh
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// data word width
`define RV_XLEN 32

// shift amount bits taken from operand b
`define RV_SHAMT_W 5

// architectural register count, x0 included
`define RV_NREGS 32

`endif

// File: verilog/rv_exec_pkg.sv
`include "rv_exec_settings.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;

    // alu control codes with fixed values
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_srl    = 4'd7,
        alu_sll    = 4'd8,
        alu_sra    = 4'd9,
        alu_sla    = 4'd10,
        alu_jal    = 4'd11,
        alu_jalr   = 4'd12,
        alu_pass_b = 4'd15
    } alu_op_e;

    // matches branch funct3 except for none
    typedef enum logic [2:0] {
        br_eq   = 3'd0,
        br_ne   = 3'd1,
        br_none = 3'd2,
        br_lt   = 3'd4,
        br_ge   = 3'd5,
        br_ltu  = 3'd6,
        br_geu  = 3'd7
    } br_op_e;

    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_alu  = 2'd1,
        wb_link = 2'd2
    } wb_sel_e;

endpackage

// File: verilog/alu.sv
`include "rv_exec_settings.svh"

module alu
    import rv_exec_pkg::*;
(
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  alu_op_e alu_op_i,
    input  br_op_e  br_op_i,
    output word_t   result_o,
    output logic    branch_o
);

    logic                  equal;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic                  is_jump;
    logic [`RV_SHAMT_W-1:0] shamt;

    assign equal       = (src_a_i == src_b_i);
    assign lt_signed   = ($signed(src_a_i) < $signed(src_b_i));
    assign lt_unsigned = (src_a_i < src_b_i);
    assign is_jump     = (alu_op_i == alu_jal) || (alu_op_i == alu_jalr);
    assign shamt       = src_b_i[`RV_SHAMT_W-1:0];

    // jumps always count as taken
    always_comb begin
        if (is_jump) begin
            branch_o = 1'b1;
        end else begin
            case (br_op_i)
                br_eq:   branch_o = equal;
                br_ne:   branch_o = !equal;
                br_lt:   branch_o = lt_signed;
                br_ge:   branch_o = !lt_signed;
                br_ltu:  branch_o = lt_unsigned;
                br_geu:  branch_o = !lt_unsigned;
                default: branch_o = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (alu_op_i)
            alu_add: result_o = src_a_i + src_b_i;
            alu_sub: result_o = src_a_i - src_b_i;
            alu_and: result_o = src_a_i & src_b_i;
            alu_or:  result_o = src_a_i | src_b_i;
            alu_xor: result_o = src_a_i ^ src_b_i;
            alu_slt: begin
                result_o = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result_o = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            end
            alu_srl: result_o = src_a_i >> shamt;
            // left shifts fill with zeros either way
            alu_sll, alu_sla: result_o = src_a_i << shamt;
            // arithmetic shift works on the signed view of a
            alu_sra: result_o = word_t'($signed(src_a_i) >>> shamt);
            // jal target arrives precomputed on b
            alu_jal:    result_o = src_b_i;
            alu_jalr:   result_o = src_a_i + src_b_i;
            alu_pass_b: result_o = src_b_i;
            default:    result_o = '0;
        endcase
    end

    // a jump code must win over any branch code
    always_comb begin
        if (is_jump) begin
            assert final (branch_o)
                else $error("alu: jump op %0d without branch", alu_op_i);
        end
    end

endmodule

// File: verilog/instr_decode.sv
`include "rv_exec_settings.svh"

module instr_decode
    import rv_exec_pkg::*;
(
    input  word_t     instr_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output reg_addr_t rd_o,
    output word_t     src_a_o,
    output word_t     src_b_o,
    output word_t     pc_imm_o,
    output alu_op_e   alu_op_o,
    output br_op_e    br_op_o,
    output wb_sel_e   wb_sel_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm;

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign alt        = instr_i[30];
    assign rd_o       = instr_i[11:7];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{(`RV_XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_b = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{(`RV_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = imm_u;
            OPC_BRANCH:         imm = imm_b;
            OPC_JAL:            imm = imm_j;
            default:            imm = imm_i;
        endcase
    end

    assign pc_imm_o = pc_i + imm;

    // funct3 to alu code, alt selects sub and sra
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return sub_sra ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        src_a_o  = rs1_data_i;
        src_b_o  = rs2_data_i;
        alu_op_o = alu_add;
        br_op_o  = br_none;
        wb_sel_o = wb_none;
        case (opcode)
            OPC_OP: begin
                alu_op_o = funct_to_alu(funct3, alt);
                wb_sel_o = wb_alu;
            end
            OPC_OP_IMM: begin
                // addi has no subtract form
                src_b_o  = imm;
                alu_op_o = funct_to_alu(funct3, alt && (funct3 == 3'b101));
                wb_sel_o = wb_alu;
            end
            OPC_LUI: begin
                src_b_o  = imm;
                alu_op_o = alu_pass_b;
                wb_sel_o = wb_alu;
            end
            OPC_AUIPC: begin
                src_a_o  = pc_i;
                src_b_o  = imm;
                wb_sel_o = wb_alu;
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    br_op_o = br_op_e'(funct3);
                end
            end
            OPC_JAL: begin
                src_b_o  = pc_imm_o;
                alu_op_o = alu_jal;
                wb_sel_o = wb_link;
            end
            OPC_JALR: begin
                src_b_o  = imm;
                alu_op_o = alu_jalr;
                wb_sel_o = wb_link;
            end
            default: begin
                wb_sel_o = wb_none;
            end
        endcase
    end

endmodule

// File: verilog/reg_file.sv
`include "rv_exec_settings.svh"

module reg_file
    import rv_exec_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  logic      we_i,
    input  reg_addr_t rd_i,
    input  word_t     rd_data_i
);

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            regs <= '{default: '0};
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    x0_zero: assert property (@(posedge clk_i) disable iff (rst_i) regs[0] == '0)
        else $error("reg_file: x0 holds %h", regs[0]);

endmodule

// File: verilog/exec_stage.sv
module exec_stage
    import rv_exec_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      valid_i,
    input  word_t     alu_result_i,
    input  logic      branch_i,
    input  word_t     pc_i,
    input  word_t     pc_imm_i,
    input  reg_addr_t rd_i,
    input  wb_sel_e   wb_sel_i,
    output logic      rf_we_o,
    output reg_addr_t rf_rd_o,
    output word_t     rf_data_o,
    output logic      valid_o,
    output word_t     result_o,
    output logic      branch_o,
    output word_t     target_o
);

    word_t link;
    word_t wb_value;
    word_t target;

    assign link     = pc_i + 4;
    assign wb_value = (wb_sel_i == wb_link) ? link : alu_result_i;
    // jumps take the alu target, branches pc plus offset
    assign target   = (wb_sel_i == wb_link) ? alu_result_i : pc_imm_i;

    // write lands on the same edge that registers the outputs
    assign rf_we_o   = valid_i && ((wb_sel_i == wb_alu) || (wb_sel_i == wb_link));
    assign rf_rd_o   = rd_i;
    assign rf_data_o = wb_value;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o  <= 1'b0;
            branch_o <= 1'b0;
            result_o <= '0;
            target_o <= '0;
        end else begin
            valid_o  <= valid_i;
            branch_o <= valid_i && branch_i;
            if (valid_i) begin
                result_o <= wb_value;
                target_o <= target;
            end
        end
    end

    branch_needs_valid: assert property (
        @(posedge clk_i) disable iff (rst_i) branch_o |-> valid_o)
        else $error("exec_stage: branch_o without valid_o");

endmodule

// File: verilog/rv_exec_top.sv
module rv_exec_top
    import rv_exec_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  instr_valid_i,
    input  word_t instr_i,
    input  word_t pc_i,
    output logic  valid_o,
    output word_t result_o,
    output logic  branch_o,
    output word_t target_o
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     src_a;
    word_t     src_b;
    word_t     pc_imm;
    alu_op_e   alu_op;
    br_op_e    br_op;
    wb_sel_e   wb_sel;
    word_t     alu_result;
    logic      alu_branch;
    logic      rf_we;
    reg_addr_t rf_rd;
    word_t     rf_data;

    instr_decode u_decode (
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_o       (rd),
        .src_a_o    (src_a),
        .src_b_o    (src_b),
        .pc_imm_o   (pc_imm),
        .alu_op_o   (alu_op),
        .br_op_o    (br_op),
        .wb_sel_o   (wb_sel)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .rd_data_i  (rf_data)
    );

    alu u_alu (
        .src_a_i  (src_a),
        .src_b_i  (src_b),
        .alu_op_i (alu_op),
        .br_op_i  (br_op),
        .result_o (alu_result),
        .branch_o (alu_branch)
    );

    exec_stage u_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (instr_valid_i),
        .alu_result_i (alu_result),
        .branch_i     (alu_branch),
        .pc_i         (pc_i),
        .pc_imm_i     (pc_imm),
        .rd_i         (rd),
        .wb_sel_i     (wb_sel),
        .rf_we_o      (rf_we),
        .rf_rd_o      (rf_rd),
        .rf_data_o    (rf_data),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .branch_o     (branch_o),
        .target_o     (target_o)
    );

endmodule

// File: tests/rv_exec_tb.sv
`include "rv_exec_settings.svh"

module rv_exec_tb
    import rv_exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETTLE_LIMIT = 20;

    // equal, signed boundary and unsigned boundary operand pairs
    localparam word_t PAIR_A [7] = '{32'd5, 32'h7fffffff, 32'h80000000, 32'hffffffff,
                                     32'd1, 32'h0, 32'hffffffff};
    localparam word_t PAIR_B [7] = '{32'd5, 32'h80000000, 32'h7fffffff, 32'd1,
                                     32'hffffffff, 32'hffffffff, 32'hffffffff};
    // load, store, fence and system
    localparam logic [6:0] BAD_OPC [4] = '{7'h03, 7'h23, 7'h0f, 7'h73};

    logic  clk_i;
    logic  rst_i;
    logic  instr_valid_i;
    word_t instr_i;
    word_t pc_i;
    logic  valid_o;
    word_t result_o;
    logic  branch_o;
    word_t target_o;

    word_t shadow [`RV_NREGS];
    word_t pend_result;
    word_t pend_target;
    logic  pend_branch;
    logic  pend_chk_result;
    logic  pend_chk_target;
    logic  exp_valid;
    word_t exp_result;
    word_t exp_target;
    logic  exp_branch;
    logic  exp_chk_result;
    logic  exp_chk_target;
    int    errors;
    int    tests_run;
    int    tests_failed;
    logic  hung;

    rv_exec_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // expected outputs follow the DUT output register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= instr_valid_i;
            if (instr_valid_i) begin
                exp_result     <= pend_result;
                exp_target     <= pend_target;
                exp_branch     <= pend_branch;
                exp_chk_result <= pend_chk_result;
                exp_chk_target <= pend_chk_target;
            end
        end
    end

    task automatic flag_mismatch(input string name, input word_t got, input word_t want);
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
        errors++;
    endtask

    reset_clears: assert property (@(posedge clk_i)
            rst_i |=> !valid_o && !branch_o && result_o == '0 && target_o == '0)
        else begin
            $display("reset did not clear the outputs");
            errors++;
        end

    valid_check: assert property (@(posedge clk_i) disable iff (rst_i)
            valid_o == exp_valid)
        else flag_mismatch("valid_o", word_t'($sampled(valid_o)),
                           word_t'($sampled(exp_valid)));

    branch_check: assert property (@(posedge clk_i) disable iff (rst_i)
            branch_o == (exp_valid && exp_branch))
        else flag_mismatch("branch_o", word_t'($sampled(branch_o)),
                           word_t'($sampled(exp_valid && exp_branch)));

    result_check: assert property (@(posedge clk_i) disable iff (rst_i)
            valid_o && exp_chk_result |-> result_o == exp_result)
        else flag_mismatch("result_o", $sampled(result_o), $sampled(exp_result));

    target_check: assert property (@(posedge clk_i) disable iff (rst_i)
            valid_o && exp_chk_target |-> target_o == exp_target)
        else flag_mismatch("target_o", $sampled(target_o), $sampled(exp_target));

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic word_t rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    // RV32I integer op semantics, alt is instruction bit 30
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'd3: return {{(`RV_XLEN-1){1'b0}}, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a,
                                          input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // model one instruction, then drive it on the next edge
    task automatic issue(input word_t instr, input word_t pc);
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      res;
        word_t      tgt;
        logic       br;
        logic       wr;
        logic       chk_tgt;
        f3      = instr[14:12];
        rd      = instr[11:7];
        a       = shadow[instr[19:15]];
        b       = shadow[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        res     = '0;
        tgt     = '0;
        br      = 1'b0;
        wr      = 1'b0;
        chk_tgt = 1'b0;
        case (instr[6:0])
            7'h33: begin
                res = alu_model(f3, instr[30], a, b);
                wr  = 1'b1;
            end
            7'h13: begin
                res = alu_model(f3, instr[30] && f3 == 3'd5, a, imm_i);
                wr  = 1'b1;
            end
            7'h37: begin
                res = {instr[31:12], 12'h000};
                wr  = 1'b1;
            end
            7'h17: begin
                res = pc + {instr[31:12], 12'h000};
                wr  = 1'b1;
            end
            7'h63: begin
                br      = branch_model(f3, a, b);
                tgt     = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                chk_tgt = 1'b1;
            end
            7'h6f: begin
                res     = pc + 4;
                br      = 1'b1;
                wr      = 1'b1;
                tgt     = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                chk_tgt = 1'b1;
            end
            7'h67: begin
                res     = pc + 4;
                br      = 1'b1;
                wr      = 1'b1;
                tgt     = a + imm_i;
                chk_tgt = 1'b1;
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        if (wr && rd != '0) begin
            shadow[rd] = res;
        end
        @(posedge clk_i);
        instr_valid_i   <= 1'b1;
        instr_i         <= instr;
        pc_i            <= pc;
        pend_result     <= res;
        pend_target     <= tgt;
        pend_branch     <= br;
        pend_chk_result <= wr;
        pend_chk_target <= chk_tgt;
    endtask

    task automatic load_reg(input reg_addr_t rd, input word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        issue(u_type(upper[19:0], rd, 7'h37), rand_pc());
        issue(i_type(value[11:0], rd, 3'd0, rd, 7'h13), rand_pc());
    endtask

    // ADDI x0, xr, 0 shows xr on result_o without writing
    task automatic read_back_all();
        for (int r = 0; r < `RV_NREGS; r++) begin
            issue(i_type(12'h000, 5'(r), 3'd0, 5'd0, 7'h13), rand_pc());
        end
    endtask

    task automatic settle();
        int waited;
        waited = 0;
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        @(negedge clk_i);
        while (valid_o && waited < SETTLE_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (valid_o) begin
            $display("timeout: valid_o still high after %0d cycles", waited);
            hung = 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        settle();
        tests_run++;
        if (errors != errors_before || hung) begin
            tests_failed++;
            $display("test %-12s FAIL (%0d errors)", name, errors - errors_before);
        end else begin
            $display("test %-12s PASS", name);
        end
    endtask

    initial begin
        int         mark;
        logic [2:0] f3;
        logic       alt;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  last_rd;
        word_t      instr;
        void'($urandom(26));
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        hung          = 1'b0;
        last_rd       = '0;
        for (int r = 0; r < `RV_NREGS; r++) begin
            shadow[r] = '0;
        end
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        mark = errors;
        read_back_all();
        end_test("reset", mark);

        mark = errors;
        for (int r = 1; r < `RV_NREGS; r++) begin
            load_reg(5'(r), $urandom);
        end
        for (int i = 0; i < 300; i++) begin
            f3  = 3'($urandom_range(7, 0));
            alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom_range(1, 0) != 0);
            rd  = 5'($urandom);
            // every fourth op reads the previous result
            rs1 = (i % 4 == 0) ? last_rd : 5'($urandom);
            if ($urandom_range(1, 0) != 0) begin
                instr = r_type({1'b0, alt, 5'b0}, 5'($urandom), rs1, f3, rd);
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                instr = i_type({1'b0, alt, 5'b0, 5'($urandom)}, rs1, f3, rd, 7'h13);
            end else begin
                instr = i_type(12'($urandom), rs1, f3, rd, 7'h13);
            end
            issue(instr, rand_pc());
            last_rd = rd;
        end
        read_back_all();
        end_test("alu_random", mark);

        mark = errors;
        issue(i_type(12'h5a5, 5'd3, 3'd0, 5'd0, 7'h13), rand_pc());
        issue(u_type(20'hfffff, 5'd0, 7'h37), rand_pc());
        issue(r_type(7'h00, 5'd4, 5'd5, 3'd6, 5'd0), rand_pc());
        issue(j_type(21'h000100, 5'd0), rand_pc());
        issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd7), rand_pc());
        read_back_all();
        end_test("x0_writes", mark);

        mark = errors;
        for (int i = 0; i < 7; i++) begin
            load_reg(5'd10, PAIR_A[i]);
            load_reg(5'd11, PAIR_B[i]);
            for (int k = 0; k < 8; k++) begin
                if (k == 2 || k == 3) begin
                    continue;
                end
                issue(b_type(13'($urandom) & 13'h1ffe, 5'd11, 5'd10, 3'(k)), rand_pc());
                issue(b_type(13'($urandom) & 13'h1ffe, 5'd10, 5'd11, 3'(k)), rand_pc());
                issue(b_type(13'($urandom) & 13'h1ffe, 5'd10, 5'd10, 3'(k)), rand_pc());
            end
        end
        read_back_all();
        end_test("branches", mark);

        mark = errors;
        for (int i = 0; i < 20; i++) begin
            rd = 5'($urandom_range(31, 1));
            issue(j_type(21'($urandom) & 21'h1ffffe, rd), rand_pc());
            // odd offsets keep bit 0 of the target
            issue(i_type(12'($urandom), 5'($urandom), 3'd0, 5'($urandom), 7'h67), rand_pc());
        end
        read_back_all();
        end_test("jumps", mark);

        mark = errors;
        for (int i = 0; i < 16; i++) begin
            issue(u_type(20'($urandom), 5'($urandom), 7'h37), rand_pc());
            issue(u_type(20'($urandom), 5'($urandom), 7'h17), rand_pc());
            issue({25'($urandom), BAD_OPC[i % 4]}, rand_pc());
        end
        read_back_all();
        end_test("upper_other", mark);

        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (hung || tests_failed != 0 || errors != 0) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

// File: rv_exec.f
+incdir+verilog
verilog/rv_exec_pkg.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/exec_stage.sv
verilog/rv_exec_top.sv
tests/rv_exec_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FILELIST  ?= rv_exec.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "test passed"; \
	else \
		echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
